// ==== common/ifu_pkg.sv ====
package ifu_pkg;

	// opcodes of the 32-bit control transfer formats
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	// compressed quadrants
	localparam logic [1:0] RVC_Q1 = 2'b01;
	localparam logic [1:0] RVC_Q2 = 2'b10;

	// compressed funct3 codes of interest
	localparam logic [2:0] C_F3_JAL = 3'b001; // rv32 only
	localparam logic [2:0] C_F3_J   = 3'b101;
	localparam logic [2:0] C_F3_CR  = 3'b100; // jr/jalr/mv/add group, q2

	// one fetched word, two readings
	typedef union packed {
		struct packed {
			logic [6:0] imm_hi; // funct7 or upper imm bits
			logic [4:0] rs2;    // also imm bits for i/j formats
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;     // low imm bits for b format
			logic [6:0] opcode;
		} rv32;
		struct packed {
			logic [15:0] upper;  // next parcel, not this inst
			logic [2:0]  funct3;
			logic        b12;    // imm msb, or jr/jalr select
			logic [4:0]  rs1_rd; // full reg, or imm + rs1' in [2:0]
			logic [4:0]  rs2;    // reg or imm bits
			logic [1:0]  op;     // 2'b11 = full 32-bit inst
		} rvc;
	} inst_word_u;

	// what the fetch stage needs to know about a word
	typedef struct packed {
		logic        inst_len_type; // 1 = 32-bit
		logic        is_b_inst;
		logic        is_jal_inst;
		logic        is_jalr_inst;
		logic [20:0] jump_ofs_imm;  // signed
		logic [4:0]  rs1_addr;
	} pre_dec_info_t;

	// packet handed to decode
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
		logic        to_jump; // predicted taken
	} fetch_pkt_t;

	// redirect from a later stage
	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
	} flush_req_t;

endpackage

// ==== hw/pre_decode.sv ====
`timescale 1ns/1ps

module pre_decode (
	input  ifu_pkg::inst_word_u    inst,
	output ifu_pkg::pre_dec_info_t info
);

	logic is_rvc;

	logic rv_b;
	logic rv_jal;
	logic rv_jalr;
	logic [20:0] rv_b_imm;
	logic [20:0] rv_j_imm;
	logic [20:0] rv_i_imm;

	logic c_b;
	logic c_j;
	logic c_jal;
	logic c_cr_jump;
	logic c_jr;
	logic c_jalr;
	logic [20:0] c_b_imm;
	logic [20:0] c_j_imm;

	assign is_rvc = (inst.rvc.op != 2'b11); // low bits pick the view

	// full-width view
	assign rv_b    = (inst.rv32.opcode == ifu_pkg::OPC_BRANCH);
	assign rv_jal  = (inst.rv32.opcode == ifu_pkg::OPC_JAL);
	assign rv_jalr = (inst.rv32.opcode == ifu_pkg::OPC_JALR) && (inst.rv32.funct3 == 3'b000);

	// imm[12|10:5] in imm_hi, imm[4:1|11] in rd
	assign rv_b_imm = {{9{inst.rv32.imm_hi[6]}}, inst.rv32.rd[0], inst.rv32.imm_hi[5:0],
		inst.rv32.rd[4:1], 1'b0};
	// imm[20|10:1|11|19:12] spread over bits 31:12
	assign rv_j_imm = {inst.rv32.imm_hi[6], inst.rv32.rs1, inst.rv32.funct3, inst.rv32.rs2[0],
		inst.rv32.imm_hi[5:0], inst.rv32.rs2[4:1], 1'b0};
	assign rv_i_imm = {{9{inst.rv32.imm_hi[6]}}, inst.rv32.imm_hi, inst.rv32.rs2}; // jalr

	// compressed view
	assign c_b   = (inst.rvc.op == ifu_pkg::RVC_Q1) && (inst.rvc.funct3[2:1] == 2'b11); // beqz/bnez
	assign c_j   = (inst.rvc.op == ifu_pkg::RVC_Q1) && (inst.rvc.funct3 == ifu_pkg::C_F3_J);
	assign c_jal = (inst.rvc.op == ifu_pkg::RVC_Q1) && (inst.rvc.funct3 == ifu_pkg::C_F3_JAL);

	// rs2 = 0 and rs1 != 0 separates jr/jalr from mv/add/ebreak
	assign c_cr_jump = (inst.rvc.op == ifu_pkg::RVC_Q2) && (inst.rvc.funct3 == ifu_pkg::C_F3_CR) &&
		(inst.rvc.rs2 == 5'd0) && (inst.rvc.rs1_rd != 5'd0);
	assign c_jr   = c_cr_jump & ~inst.rvc.b12;
	assign c_jalr = c_cr_jump & inst.rvc.b12;

	// cb format, imm[8|4:3] at 12:10 and imm[7:6|2:1|5] at 6:2
	assign c_b_imm = {{13{inst.rvc.b12}}, inst.rvc.rs2[4:3], inst.rvc.rs2[0],
		inst.rvc.rs1_rd[4:3], inst.rvc.rs2[2:1], 1'b0};
	// cj format, imm[11|4|9:8|10|6|7|3:1|5]
	assign c_j_imm = {{10{inst.rvc.b12}}, inst.rvc.rs1_rd[1], inst.rvc.rs1_rd[3:2],
		inst.rvc.rs2[4], inst.rvc.rs1_rd[0], inst.rvc.rs2[0], inst.rvc.rs1_rd[4],
		inst.rvc.rs2[3:1], 1'b0};

	always_comb begin
		info = '0;
		info.inst_len_type = ~is_rvc;
		if (is_rvc) begin
			info.is_b_inst    = c_b;
			info.is_jal_inst  = c_j | c_jal;
			info.is_jalr_inst = c_jr | c_jalr; // offset stays 0
			if (c_b)
				info.jump_ofs_imm = c_b_imm;
			else if (c_j | c_jal)
				info.jump_ofs_imm = c_j_imm;
			// rs1' maps onto x8..x15
			info.rs1_addr = c_b ? {2'b01, inst.rvc.rs1_rd[2:0]} : inst.rvc.rs1_rd;
		end else begin
			info.is_b_inst    = rv_b;
			info.is_jal_inst  = rv_jal;
			info.is_jalr_inst = rv_jalr;
			if (rv_b)
				info.jump_ofs_imm = rv_b_imm;
			else if (rv_jal)
				info.jump_ofs_imm = rv_j_imm;
			else if (rv_jalr)
				info.jump_ofs_imm = rv_i_imm;
			info.rs1_addr = inst.rv32.rs1;
		end
	end

endmodule

// ==== hw/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen #(
	parameter logic [31:0] RST_PC = 32'h0000_0000
) (
	input  logic [31:0]            now_pc,
	input  logic                   to_rst,          // first cycle out of reset
	input  logic                   to_flush,        // redirect pending
	input  logic [31:0]            flush_addr_hold,
	input  logic [31:0]            rs1_v,           // jalr base
	input  ifu_pkg::pre_dec_info_t info,
	output logic                   to_jump,
	output logic [31:0]            new_pc
);

	logic [31:0] seq_step;
	logic [31:0] jump_ofs;
	logic [31:0] add_base;
	logic [31:0] add_ofs;
	logic [31:0] pc_sum;
	logic [31:0] pc_nxt;

	// static guess
	// backward branch taken, forward branch not, jumps always
	assign to_jump = (info.is_b_inst & info.jump_ofs_imm[20]) | info.is_jal_inst |
		info.is_jalr_inst;

	assign seq_step = info.inst_len_type ? 32'd4 : 32'd2;
	assign jump_ofs = {{11{info.jump_ofs_imm[20]}}, info.jump_ofs_imm}; // sign extend

	// one adder serves both the target and the fall-through
	assign add_base = (to_jump & info.is_jalr_inst) ? rs1_v : now_pc;
	assign add_ofs  = to_jump ? jump_ofs : seq_step;
	assign pc_sum   = add_base + add_ofs;

	// jalr target drops bit 0
	assign pc_nxt = info.is_jalr_inst ? {pc_sum[31:1], 1'b0} : pc_sum;

	// reset beats flush beats the sum
	always_comb begin
		if (to_rst)
			new_pc = RST_PC;
		else if (to_flush)
			new_pc = flush_addr_hold;
		else
			new_pc = pc_nxt;
	end

endmodule

// ==== fetch/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl (
	input  logic                clk,
	input  logic                reset,
	input  ifu_pkg::flush_req_t flush,

	// instruction memory
	output logic                imem_req,
	output logic [31:0]         imem_addr,
	input  logic                imem_resp_valid,
	input  logic [31:0]         imem_rdata,

	// from pc_gen
	input  logic [31:0]         new_pc,
	input  logic                to_jump,

	input  logic                queue_free,

	// state out to pc_gen
	output logic [31:0]         now_pc,
	output logic                to_rst,
	output logic                to_flush,
	output logic [31:0]         flush_addr_hold,

	// into the queue
	output logic                push,
	output ifu_pkg::fetch_pkt_t push_pkt
);

	logic outstanding; // one request in flight
	logic resp;        // response to our request this cycle
	logic stale;       // response belongs to the old path
	logic flush_take;  // pc takes the held flush addr
	logic pc_upd;

	assign resp  = outstanding & imem_resp_valid;
	assign stale = to_flush | flush.valid;
	assign push  = resp & ~stale;

	// with a request in flight the flush waits for its response, which is dropped
	assign flush_take = to_flush & ~to_rst & (~outstanding | resp);
	assign pc_upd     = to_rst | flush_take | push;

	// no new fetch until the redirect has landed in the pc
	assign imem_req  = ~outstanding & ~to_rst & ~to_flush & ~flush.valid & queue_free;
	assign imem_addr = now_pc;

	assign push_pkt = '{pc: now_pc, inst: imem_rdata, to_jump: to_jump};

	// forces new_pc = RST_PC right after reset
	always_ff @(posedge clk) begin
		if (reset)
			to_rst <= 1'b1;
		else
			to_rst <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (reset)
			outstanding <= 1'b0;
		else if (imem_req)
			outstanding <= 1'b1;
		else if (resp)
			outstanding <= 1'b0;
	end

	// a newer flush overwrites one still held
	always_ff @(posedge clk) begin
		if (reset)
			to_flush <= 1'b0;
		else if (flush.valid)
			to_flush <= 1'b1;
		else if (flush_take)
			to_flush <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (flush.valid)
			flush_addr_hold <= flush.addr;
	end

	// loaded with RST_PC via to_rst
	always_ff @(posedge clk) begin
		if (pc_upd)
			now_pc <= new_pc;
	end

	// no second request before the first is answered
	a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
		imem_req |=> (!imem_req until_with imem_resp_valid));

	a_resp_requested: assert property (@(posedge clk) disable iff (reset)
		imem_resp_valid |-> outstanding);

	// slot was checked at request time
	a_push_has_room: assert property (@(posedge clk) disable iff (reset)
		push |-> queue_free);

endmodule

// ==== fetch/fetch_queue.sv ====
`timescale 1ns/1ps

module fetch_queue #(
	parameter int QUEUE_DEPTH = 4,
	parameter int DEC_CREDITS = 2
) (
	input  logic                clk,
	input  logic                reset,

	input  logic                push,
	input  ifu_pkg::fetch_pkt_t push_pkt,
	output logic                queue_free,

	// decode side
	input  logic                dec_credit_return, // one slot freed in decode
	output logic                out_valid,
	output ifu_pkg::fetch_pkt_t out_pkt
);

	localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CW = $clog2(QUEUE_DEPTH + 1);
	localparam int KW = $clog2(DEC_CREDITS + 1);

	localparam logic [PW-1:0] LAST_SLOT = PW'(QUEUE_DEPTH - 1);
	localparam logic [CW-1:0] FULL_CNT  = CW'(QUEUE_DEPTH);
	localparam logic [KW-1:0] MAX_CRED  = KW'(DEC_CREDITS);

	ifu_pkg::fetch_pkt_t slots [QUEUE_DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;   // packets held
	logic [KW-1:0] credits; // free slots in decode

	assign queue_free = (count != FULL_CNT);
	assign out_valid  = (count != '0) && (credits != '0); // send = pop
	assign out_pkt    = slots[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			slots[wr_ptr] <= push_pkt;
	end

	// pointers wrap at depth, not at a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			if (out_valid)
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			count <= '0;
		else if (push && !out_valid)
			count <= count + 1'b1;
		else if (!push && out_valid)
			count <= count - 1'b1;
	end

	// decode starts empty
	always_ff @(posedge clk) begin
		if (reset)
			credits <= MAX_CRED;
		else if (out_valid && !dec_credit_return)
			credits <= credits - 1'b1;
		else if (!out_valid && dec_credit_return)
			credits <= credits + 1'b1;
	end

	// decode never returns more than it was given
	a_credit_bound: assert property (@(posedge clk) disable iff (reset)
		credits <= MAX_CRED);

	a_no_send_dry: assert property (@(posedge clk) disable iff (reset)
		(credits == '0 && !dec_credit_return) |=> !out_valid);

endmodule

// ==== hw/ifu_top.sv ====
`timescale 1ns/1ps

module ifu_top #(
	parameter logic [31:0] RST_PC      = 32'h0000_0000,
	parameter int          QUEUE_DEPTH = 4,
	parameter int          DEC_CREDITS = 2
) (
	input  logic                clk,
	input  logic                reset,
	input  ifu_pkg::flush_req_t flush,

	output logic                imem_req,
	output logic [31:0]         imem_addr,
	input  logic                imem_resp_valid,
	input  logic [31:0]         imem_rdata,

	output logic [4:0]          rs1_addr, // comb read, same cycle
	input  logic [31:0]         rs1_v,

	output logic                out_valid,
	output ifu_pkg::fetch_pkt_t out_pkt,
	input  logic                dec_credit_return
);

	logic [31:0]            now_pc;
	logic                   to_rst;
	logic                   to_flush;
	logic [31:0]            flush_addr_hold;
	logic [31:0]            new_pc;
	logic                   to_jump;
	logic                   queue_free;
	logic                   push;
	ifu_pkg::fetch_pkt_t    push_pkt;
	ifu_pkg::pre_dec_info_t pd_info;

	assign rs1_addr = pd_info.rs1_addr;

	fetch_ctrl u_fetch_ctrl (
		.clk(clk), .reset(reset), .flush(flush),
		.imem_req(imem_req), .imem_addr(imem_addr),
		.imem_resp_valid(imem_resp_valid), .imem_rdata(imem_rdata),
		.new_pc(new_pc), .to_jump(to_jump), .queue_free(queue_free),
		.now_pc(now_pc), .to_rst(to_rst), .to_flush(to_flush),
		.flush_addr_hold(flush_addr_hold),
		.push(push), .push_pkt(push_pkt)
	);

	// the raw memory word is decoded before it is registered anywhere
	pre_decode u_pre_decode (
		.inst(ifu_pkg::inst_word_u'(imem_rdata)),
		.info(pd_info)
	);

	pc_gen #(.RST_PC(RST_PC)) u_pc_gen (
		.now_pc(now_pc), .to_rst(to_rst), .to_flush(to_flush),
		.flush_addr_hold(flush_addr_hold), .rs1_v(rs1_v), .info(pd_info),
		.to_jump(to_jump), .new_pc(new_pc)
	);

	fetch_queue #(.QUEUE_DEPTH(QUEUE_DEPTH), .DEC_CREDITS(DEC_CREDITS)) u_fetch_queue (
		.clk(clk), .reset(reset),
		.push(push), .push_pkt(push_pkt), .queue_free(queue_free),
		.dec_credit_return(dec_credit_return),
		.out_valid(out_valid), .out_pkt(out_pkt)
	);

endmodule

// ==== verif/imem_model.sv ====
`timescale 1ns/1ps

module imem_model (
	input  logic        clk,
	input  logic        reset,
	input  logic        req,
	input  logic [31:0] addr,
	output logic        resp_valid,
	output logic [31:0] rdata
);

	logic [15:0] mem [1024]; // halfword image, written by the test

	integer      seed;
	int          lat;
	int          wait_left;
	logic        busy;
	logic [31:0] addr_q;
	logic        req_s;
	logic [31:0] addr_s;
	logic        reset_s;

	// 32 bits from any halfword, no alignment needed
	function automatic logic [31:0] read_word(input logic [31:0] a);
		logic [9:0] idx;
		idx = a[10:1];
		return {mem[idx + 10'd1], mem[idx]};
	endfunction

	initial begin
		seed = 32'hf27a;
		resp_valid = 1'b0;
		rdata = '0;
		busy = 1'b0;
		wait_left = 0;
		addr_q = '0;
	end

	always @(posedge clk) begin
		req_s = req; // sampled at the edge
		addr_s = addr;
		reset_s = reset;
		#1;
		resp_valid = 1'b0;
		if (reset_s) begin
			busy = 1'b0;
		end else if (req_s) begin
			lat = {$random(seed)} % 4; // 0 means answer in the next cycle
			if (lat == 0) begin
				resp_valid = 1'b1;
				rdata = read_word(addr_s);
			end else begin
				busy = 1'b1;
				wait_left = lat - 1;
				addr_q = addr_s;
			end
		end else if (busy) begin
			if (wait_left == 0) begin
				resp_valid = 1'b1;
				rdata = read_word(addr_q);
				busy = 1'b0;
			end else begin
				wait_left = wait_left - 1;
			end
		end
	end

endmodule

// ==== verif/tb_ifu.sv ====
`timescale 1ns/1ps

module tb_ifu;

	localparam logic [31:0] RST_PC = 32'h0000_0000;
	localparam int QUEUE_DEPTH = 4;
	localparam int DEC_CREDITS = 2;
	localparam int CLK_PERIOD = 20;
	localparam int NUM_TESTS = 5;

	logic                clk;
	logic                reset;
	ifu_pkg::flush_req_t flush;
	logic                imem_req;
	logic [31:0]         imem_addr;
	logic                imem_resp_valid;
	logic [31:0]         imem_rdata;
	logic [4:0]          rs1_addr;
	logic [31:0]         rs1_v;
	logic                out_valid;
	ifu_pkg::fetch_pkt_t out_pkt;
	logic                dec_credit_return;

	logic [31:0] rf [32];      // register file model
	logic [31:0] nxt_tab [1024]; // expected successor per halfword
	logic        jmp_tab [1024]; // expected prediction per halfword

	integer      seed;
	int          errors;
	int          err_mark;
	int          ntests;
	logic        hold_credits; // decode stalled and keeping its slots
	int          sent;
	int          returned;
	int          out_cnt;
	int          resp_ok;   // responses that must become packets
	int          flush_idx; // packet number that must be the flush target
	logic        skip_resp;
	logic        imem_busy;
	logic [31:0] flush_tgt;
	logic [31:0] chain_pc;
	logic [31:0] exp_pc;
	logic [31:0] exp_inst;
	logic        exp_jump;
	logic [9:0]  pc_idx;

	assign rs1_v = rf[rs1_addr]; // comb read

	ifu_top #(
		.RST_PC(RST_PC), .QUEUE_DEPTH(QUEUE_DEPTH), .DEC_CREDITS(DEC_CREDITS)
	) u_ifu_top (
		.clk(clk), .reset(reset), .flush(flush),
		.imem_req(imem_req), .imem_addr(imem_addr),
		.imem_resp_valid(imem_resp_valid), .imem_rdata(imem_rdata),
		.rs1_addr(rs1_addr), .rs1_v(rs1_v),
		.out_valid(out_valid), .out_pkt(out_pkt), .dec_credit_return(dec_credit_return)
	);

	imem_model u_imem (
		.clk(clk), .reset(reset), .req(imem_req), .addr(imem_addr),
		.resp_valid(imem_resp_valid), .rdata(imem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(NUM_TESTS * 400 * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, fetch stopped making progress",
			NUM_TESTS * 400);
		$display("Simulation failed");
		$finish;
	end

	assign pc_idx   = out_pkt.pc[10:1];
	assign exp_inst = {u_imem.mem[pc_idx + 10'd1], u_imem.mem[pc_idx]};
	assign exp_jump = jmp_tab[pc_idx];
	assign exp_pc   = (out_cnt == flush_idx) ? flush_tgt : chain_pc; // redirect wins once

	always @(posedge clk) begin
		if (reset) begin
			out_cnt <= 0;
			chain_pc <= RST_PC;
			sent <= 0;
			returned <= 0;
			resp_ok <= 0;
			flush_idx <= -1;
			skip_resp <= 1'b0;
			imem_busy <= 1'b0;
			flush_tgt <= '0;
		end else begin
			if (out_valid) begin
				out_cnt <= out_cnt + 1;
				chain_pc <= nxt_tab[pc_idx];
				sent <= sent + 1;
			end
			if (dec_credit_return)
				returned <= returned + 1;
			if (imem_req)
				imem_busy <= 1'b1;
			else if (imem_resp_valid)
				imem_busy <= 1'b0;
			if (flush.valid) begin
				flush_idx <= resp_ok; // everything accepted so far drains first
				flush_tgt <= flush.addr;
				skip_resp <= imem_busy && !imem_resp_valid; // in-flight one is dropped
			end else if (imem_resp_valid) begin
				if (skip_resp)
					skip_resp <= 1'b0;
				else
					resp_ok <= resp_ok + 1;
			end
		end
	end

	task automatic mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
		$display("MISMATCH time %0t: %s got %h expected %h", $time, sig, got, exp);
		errors++;
	endtask

	a_pkt_pc: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> out_pkt.pc == exp_pc)
		else mismatch("out_pkt.pc", $sampled(out_pkt.pc), $sampled(exp_pc));

	a_pkt_inst: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> out_pkt.inst == exp_inst)
		else mismatch("out_pkt.inst", $sampled(out_pkt.inst), $sampled(exp_inst));

	a_pkt_jump: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> out_pkt.to_jump == exp_jump)
		else mismatch("out_pkt.to_jump", {31'd0, $sampled(out_pkt.to_jump)},
			{31'd0, $sampled(exp_jump)});

	a_credit_use: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> sent < DEC_CREDITS + returned)
		else begin
			$display("time %0t: packet sent to decode without a free credit", $time);
			errors++;
		end

	// memory side allows one request at a time
	a_req_single: assert property (@(posedge clk) disable iff (reset)
		imem_req |-> !imem_busy)
		else begin
			$display("time %0t: memory request issued while another was in flight", $time);
			errors++;
		end

	a_req_align: assert property (@(posedge clk) disable iff (reset)
		imem_req |-> imem_addr[0] == 1'b0)
		else mismatch("imem_addr[0]", {31'd0, $sampled(imem_addr[0])}, 32'd0);

	// decode frees slots at random gaps unless stalled
	initial begin
		forever begin
			@(posedge clk);
			#1;
			dec_credit_return = !reset && !hold_credits && (sent - returned > 0) &&
				({$random(seed)} % 3 == 0);
		end
	end

	task automatic put_inst(input logic [31:0] addr, input logic [31:0] word,
		input logic [31:0] nxt, input logic jump);
		u_imem.mem[addr[10:1]] = word[15:0];
		if (word[1:0] == 2'b11)
			u_imem.mem[addr[10:1] + 10'd1] = word[31:16];
		nxt_tab[addr[10:1]] = nxt;
		jmp_tab[addr[10:1]] = jump;
	endtask

	task automatic load_program();
		for (int i = 0; i < 1024; i++) begin
			u_imem.mem[i] = {4'b0000, i[9:0], 2'b01}; // c.addi with fields from the index
			nxt_tab[i] = {21'd0, i[9:0], 1'b0} + 32'd2;
			jmp_tab[i] = 1'b0;
		end
		for (int r = 0; r < 32; r++)
			rf[r] = '0;
		rf[5] = 32'h0000_0100;
		rf[6] = 32'h0000_0080;
		put_inst(32'h000, 32'h0010_0093, 32'h004, 1'b0); // addi
		put_inst(32'h004, 32'h0000_0001, 32'h006, 1'b0); // c.nop
		put_inst(32'h006, 32'h0010_0093, 32'h00a, 1'b0); // addi on a halfword
		put_inst(32'h00a, 32'h0000_0001, 32'h00c, 1'b0);
		put_inst(32'h00c, 32'h0000_0463, 32'h010, 1'b0); // beq +8 forward so falls through
		put_inst(32'h010, 32'h0000_c011, 32'h012, 1'b0); // c.beqz +4 forward
		put_inst(32'h012, 32'h0200_006f, 32'h032, 1'b1); // jal +0x20
		put_inst(32'h032, 32'h0000_a801, 32'h042, 1'b1); // c.j +0x10
		put_inst(32'h042, 32'h0042_8067, 32'h104, 1'b1); // jalr 4(x5)
		put_inst(32'h104, 32'h0000_8302, 32'h080, 1'b1); // c.jr x6
		put_inst(32'h082, 32'hfe00_0de3, 32'h07c, 1'b1); // beq -6 backward
		put_inst(32'h07c, 32'h0000_d051, 32'h000, 1'b1); // c.beqz -124 closes the loop
	endtask

	task automatic wait_pkts(input int n);
		int target;
		target = out_cnt + n;
		while (out_cnt < target)
			@(posedge clk);
		#1;
	endtask

	task automatic send_flush(input logic [31:0] addr);
		flush = '{valid: 1'b1, addr: addr};
		@(posedge clk);
		#1;
		flush = '0;
		while (out_cnt <= flush_idx) // until the target packet is out
			@(posedge clk);
		#1;
	endtask

	task automatic end_test(input string name);
		ntests++;
		$display("test %0d %s: %0d errors", ntests, name, errors - err_mark);
		err_mark = errors;
	endtask

	initial begin
		seed = 32'hf27a;
		errors = 0;
		err_mark = 0;
		ntests = 0;
		hold_credits = 1'b0;
		reset = 1'b1;
		flush = '0;
		dec_credit_return = 1'b0;
		load_program();
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		wait_pkts(8);
		end_test("sequential");
		wait_pkts(18);
		end_test("static branch");
		wait_pkts(13);
		end_test("jumps");

		while (!imem_busy) begin // request in flight
			@(posedge clk);
			#1;
		end
		send_flush(32'h0000_000c);
		hold_credits = 1'b1; // queue fills, fetch goes idle
		repeat (80) @(posedge clk);
		#1;
		while (imem_busy) begin
			@(posedge clk);
			#1;
		end
		hold_credits = 1'b0;
		send_flush(32'h0000_0042);
		end_test("flush");

		repeat (3) begin
			hold_credits = 1'b1;
			repeat (60) @(posedge clk);
			#1;
			hold_credits = 1'b0;
			wait_pkts(8);
		end
		end_test("credits");

		$display("tests run %0d, errors %0d", ntests, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== project.f ====
common/ifu_pkg.sv
hw/pre_decode.sv
hw/pc_gen.sv
fetch/fetch_ctrl.sv
fetch/fetch_queue.sv
hw/ifu_top.sv
verif/imem_model.sv
verif/tb_ifu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ifu
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
